//--- source/wh_pkg.sv
`default_nettype none

package wh_pkg;

  // bits carried by one link flit
  localparam int flit_width_lp = 16;

  // the wormhole header and the protocol header share one word
  localparam int hdr_width_lp = 32;
  localparam int data_width_lp = 32;

  // flits needed for one header word and for one data word
  localparam int hdr_flits_lp = hdr_width_lp / flit_width_lp;
  localparam int data_flits_lp = data_width_lp / flit_width_lp;

  // wormhole header fields
  localparam int cord_width_lp = 4;
  localparam int len_width_lp = 4;
  localparam int pr_hdr_width_lp = hdr_width_lp - cord_width_lp - len_width_lp;

  // a packet carries zero to three data words
  localparam int max_words_lp = 3;

  // depth of the in-flight flit buffer, kept a power of two so pointers wrap
  localparam int fifo_els_lp = 4;
  localparam int fifo_ptr_width_lp = $clog2(fifo_els_lp);
  localparam int fifo_cnt_width_lp = $clog2(fifo_els_lp + 1);

  // producer phases
  localparam logic [1:0] in_idle_lp = 2'd0;
  localparam logic [1:0] in_hdr0_lp = 2'd1;
  localparam logic [1:0] in_hdr1_lp = 2'd2;
  localparam logic [1:0] in_data_lp = 2'd3;

  // cord sits in the lowest bits so that it leads the first flit
  typedef struct packed {
    logic [pr_hdr_width_lp-1:0] pr_hdr;
    logic [len_width_lp-1:0]    len;
    logic [cord_width_lp-1:0]   cord;
  } wh_hdr_s;

  // the producer walks the flits view, the consumer side decodes fields
  typedef union packed {
    wh_hdr_s                                     fields;
    logic [hdr_flits_lp-1:0][flit_width_lp-1:0] flits;
  } wh_hdr_u;

endpackage

`default_nettype wire

//--- source/wh_stream_in.sv
`timescale 1ns/100ps
`default_nettype none

module wh_stream_in
  (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    input  wh_pkg::wh_hdr_u                  in_hdr_i,
    input  logic                             in_hdr_v_i,
    output logic                             in_hdr_ready_o,

    input  logic [wh_pkg::data_width_lp-1:0] in_data_i,
    input  logic                             in_data_v_i,
    output logic                             in_data_ready_o,

    output logic [wh_pkg::flit_width_lp-1:0] link_data_o,
    output logic                             link_v_o,
    input  logic                             link_ready_i
  );

  logic [1:0]                        state_r;
  wh_pkg::wh_hdr_u                   hdr_r;
  logic [wh_pkg::flit_width_lp-1:0]  data_hi_r;
  // set while the upper flit of the current data word still has to leave
  logic                              pend_r;
  logic [wh_pkg::len_width_lp-1:0]   words_r;
  logic                              link_accept;

  // a new header is taken only once the previous packet has fully left
  assign in_hdr_ready_o = (state_r == wh_pkg::in_idle_lp);

  // the lower flit of a data word goes straight out, so the word is taken
  // in the same cycle the link takes that flit
  assign in_data_ready_o = (state_r == wh_pkg::in_data_lp) & ~pend_r & link_ready_i;

  always_comb
  begin
    link_v_o = 1'b0;
    link_data_o = hdr_r.flits[0];
    case (state_r)
      wh_pkg::in_hdr0_lp:
      begin
        link_v_o = 1'b1;
        link_data_o = hdr_r.flits[0];
      end
      wh_pkg::in_hdr1_lp:
      begin
        link_v_o = 1'b1;
        link_data_o = hdr_r.flits[1];
      end
      wh_pkg::in_data_lp:
      begin
        if (pend_r)
        begin
          link_v_o = 1'b1;
          link_data_o = data_hi_r;
        end
        else
        begin
          link_v_o = in_data_v_i;
          link_data_o = in_data_i[wh_pkg::flit_width_lp-1:0];
        end
      end
      default:
      begin
        link_v_o = 1'b0;
      end
    endcase
  end

  assign link_accept = link_v_o & link_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= wh_pkg::in_idle_lp;
      pend_r <= 1'b0;
      words_r <= '0;
    end
    else
    begin
      case (state_r)
        wh_pkg::in_idle_lp:
        begin
          if (in_hdr_v_i)
          begin
            state_r <= wh_pkg::in_hdr0_lp;
            // len counts the second header flit plus two flits per word
            words_r <= in_hdr_i.fields.len >> 1;
          end
        end
        wh_pkg::in_hdr0_lp:
        begin
          if (link_accept)
            state_r <= wh_pkg::in_hdr1_lp;
        end
        wh_pkg::in_hdr1_lp:
        begin
          if (link_accept)
            state_r <= (words_r == '0) ? wh_pkg::in_idle_lp : wh_pkg::in_data_lp;
        end
        default:
        begin
          if (link_accept && !pend_r)
            pend_r <= 1'b1;
          else if (link_accept)
          begin
            pend_r <= 1'b0;
            words_r <= words_r - wh_pkg::len_width_lp'(1);
            if (words_r == wh_pkg::len_width_lp'(1))
              state_r <= wh_pkg::in_idle_lp;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (in_hdr_v_i && in_hdr_ready_o)
      hdr_r <= in_hdr_i;
    if (in_data_v_i && in_data_ready_o)
      data_hi_r <= in_data_i[wh_pkg::flit_width_lp +: wh_pkg::flit_width_lp];
  end

  // data words are only offered while a header is in progress
  a_data_after_hdr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_r == wh_pkg::in_idle_lp) |-> !in_data_v_i);

endmodule

`default_nettype wire

//--- source/wh_flit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module wh_flit_fifo
  (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    input  logic [wh_pkg::flit_width_lp-1:0] data_i,
    input  logic                             v_i,
    output logic                             ready_o,

    output logic [wh_pkg::flit_width_lp-1:0] data_o,
    output logic                             v_o,
    input  logic                             ready_i
  );

  logic [wh_pkg::flit_width_lp-1:0]     mem_r [wh_pkg::fifo_els_lp];
  logic [wh_pkg::fifo_ptr_width_lp-1:0] wr_ptr_r;
  logic [wh_pkg::fifo_ptr_width_lp-1:0] rd_ptr_r;
  logic [wh_pkg::fifo_cnt_width_lp-1:0] cnt_r;
  logic                                 push;
  logic                                 pop;

  // a full buffer refuses a push even when it pops in the same cycle
  assign ready_o = (cnt_r != wh_pkg::fifo_cnt_width_lp'(wh_pkg::fifo_els_lp));
  assign v_o = (cnt_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop = v_o & ready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r <= '0;
    end
    else
    begin
      // pointers wrap on their own since the depth is a power of two
      if (push)
        wr_ptr_r <= wr_ptr_r + wh_pkg::fifo_ptr_width_lp'(1);
      if (pop)
        rd_ptr_r <= rd_ptr_r + wh_pkg::fifo_ptr_width_lp'(1);
      if (push && !pop)
        cnt_r <= cnt_r + wh_pkg::fifo_cnt_width_lp'(1);
      else if (pop && !push)
        cnt_r <= cnt_r - wh_pkg::fifo_cnt_width_lp'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  // a flit refused by a full buffer stays offered until it is taken
  a_no_drop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (v_i && !ready_o) |=> (v_i && $stable(data_i)));

endmodule

`default_nettype wire

//--- source/wh_stream_control.sv
`timescale 1ns/100ps
`default_nettype none

module wh_stream_control
  (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic [wh_pkg::len_width_lp-1:0] len_i,
    input  logic                            link_accept_i,

    output logic                            is_hdr_o,
    output logic                            is_data_o
  );

  // low while waiting for the first flit of the next packet
  logic                            busy_r;
  // flits of the packet still to come after the last accepted one
  logic [wh_pkg::len_width_lp-1:0] rem_r;
  // header flits still to come after the last accepted one
  logic [wh_pkg::len_width_lp-1:0] hdr_left_r;

  // the first flit of a packet is always a header flit
  assign is_hdr_o = ~busy_r | (hdr_left_r != '0);
  assign is_data_o = ~is_hdr_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      rem_r <= '0;
      hdr_left_r <= '0;
    end
    else if (link_accept_i)
    begin
      if (!busy_r)
      begin
        // len_i is only meaningful on this first flit
        rem_r <= len_i;
        hdr_left_r <= wh_pkg::len_width_lp'(wh_pkg::hdr_flits_lp - 1);
        busy_r <= (len_i != '0);
      end
      else
      begin
        rem_r <= rem_r - wh_pkg::len_width_lp'(1);
        if (hdr_left_r != '0)
          hdr_left_r <= hdr_left_r - wh_pkg::len_width_lp'(1);
        // the packet ends with the flit that brings the count to zero
        busy_r <= (rem_r != wh_pkg::len_width_lp'(1));
      end
    end
  end

endmodule

`default_nettype wire

//--- source/wh_flit_sipo.sv
`timescale 1ns/100ps
`default_nettype none

module wh_flit_sipo
  #(
    parameter int els_p = 2
  )
  (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    input  logic [wh_pkg::flit_width_lp-1:0]       data_i,
    input  logic                                   v_i,
    output logic                                   ready_o,

    output logic [els_p*wh_pkg::flit_width_lp-1:0] data_o,
    output logic                                   v_o,
    input  logic                                   yumi_i
  );

  localparam int cnt_width_lp = $clog2(els_p + 1);

  logic [els_p-1:0][wh_pkg::flit_width_lp-1:0] slot_r;
  // number of slots filled so far, equal to els_p once the word is whole
  logic [cnt_width_lp-1:0]                     cnt_r;
  logic                                        accept;

  assign v_o = (cnt_r == cnt_width_lp'(els_p));
  // a complete word blocks further flits until the client takes it
  assign ready_o = ~v_o;
  assign data_o = slot_r;

  assign accept = v_i & ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      cnt_r <= '0;
    else if (yumi_i)
      cnt_r <= '0;
    else if (accept)
      cnt_r <= cnt_r + cnt_width_lp'(1);
  end

  // the fill count selects the slot, so flit 0 lands in the low bits
  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < els_p; i++)
    begin
      if (accept && (cnt_r == cnt_width_lp'(i)))
        slot_r[i] <= data_i;
    end
  end

  a_yumi_on_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- source/wh_stream_out.sv
`timescale 1ns/100ps
`default_nettype none

module wh_stream_out
  (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    input  logic [wh_pkg::flit_width_lp-1:0] link_data_i,
    input  logic                             link_v_i,
    output logic                             link_ready_o,

    output wh_pkg::wh_hdr_u                  hdr_o,
    output logic                             hdr_v_o,
    input  logic                             hdr_yumi_i,

    output logic [wh_pkg::data_width_lp-1:0] data_o,
    output logic                             data_v_o,
    input  logic                             data_yumi_i
  );

  logic is_hdr;
  logic is_data;
  logic link_accept;
  logic hdr_v_li;
  logic hdr_ready_lo;
  logic data_v_li;
  logic data_ready_lo;

  // a flit is accepted only when the gatherer it is steered to has room
  assign link_ready_o = is_hdr ? hdr_ready_lo : data_ready_lo;
  assign link_accept = link_ready_o & link_v_i;

  // header flits build one header word that the client acks as a whole
  assign hdr_v_li = is_hdr & link_v_i;

  wh_flit_sipo
    #(
      .els_p (wh_pkg::hdr_flits_lp)
    )
    hdr_sipo
    (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (link_data_i),
      .v_i     (hdr_v_li),
      .ready_o (hdr_ready_lo),
      .data_o  (hdr_o),
      .v_o     (hdr_v_o),
      .yumi_i  (hdr_yumi_i)
    );

  // data flits are paired into protocol words and handed out one by one,
  // so a packet never has to be held in full
  assign data_v_li = is_data & link_v_i;

  wh_flit_sipo
    #(
      .els_p (wh_pkg::data_flits_lp)
    )
    data_sipo
    (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (link_data_i),
      .v_i     (data_v_li),
      .ready_o (data_ready_lo),
      .data_o  (data_o),
      .v_o     (data_v_o),
      .yumi_i  (data_yumi_i)
    );

  // len sits just above cord in the first flit of each packet
  wh_stream_control stream_control
    (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .len_i         (link_data_i[wh_pkg::cord_width_lp +: wh_pkg::len_width_lp]),
      .link_accept_i (link_accept),
      .is_hdr_o      (is_hdr),
      .is_data_o     (is_data)
    );

  // every packet holds the second header flit plus whole data words
  a_len_odd : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hdr_v_o |-> hdr_o.fields.len[0]);

endmodule

`default_nettype wire

//--- source/wh_loopback_top.sv
`timescale 1ns/100ps
`default_nettype none

module wh_loopback_top
  (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    input  wh_pkg::wh_hdr_u                  in_hdr_i,
    input  logic                             in_hdr_v_i,
    output logic                             in_hdr_ready_o,

    input  logic [wh_pkg::data_width_lp-1:0] in_data_i,
    input  logic                             in_data_v_i,
    output logic                             in_data_ready_o,

    output wh_pkg::wh_hdr_u                  hdr_o,
    output logic                             hdr_v_o,
    input  logic                             hdr_yumi_i,

    output logic [wh_pkg::data_width_lp-1:0] data_o,
    output logic                             data_v_o,
    input  logic                             data_yumi_i
  );

  // producer side of the link, into the buffer
  logic [wh_pkg::flit_width_lp-1:0] tx_data;
  logic                             tx_v;
  logic                             tx_ready;

  // buffer output, into the consumer
  logic [wh_pkg::flit_width_lp-1:0] rx_data;
  logic                             rx_v;
  logic                             rx_ready;

  wh_stream_in stream_in
    (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .in_hdr_i        (in_hdr_i),
      .in_hdr_v_i      (in_hdr_v_i),
      .in_hdr_ready_o  (in_hdr_ready_o),
      .in_data_i       (in_data_i),
      .in_data_v_i     (in_data_v_i),
      .in_data_ready_o (in_data_ready_o),
      .link_data_o     (tx_data),
      .link_v_o        (tx_v),
      .link_ready_i    (tx_ready)
    );

  wh_flit_fifo flit_fifo
    (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (tx_data),
      .v_i     (tx_v),
      .ready_o (tx_ready),
      .data_o  (rx_data),
      .v_o     (rx_v),
      .ready_i (rx_ready)
    );

  wh_stream_out stream_out
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .link_data_i  (rx_data),
      .link_v_i     (rx_v),
      .link_ready_o (rx_ready),
      .hdr_o        (hdr_o),
      .hdr_v_o      (hdr_v_o),
      .hdr_yumi_i   (hdr_yumi_i),
      .data_o       (data_o),
      .data_v_o     (data_v_o),
      .data_yumi_i  (data_yumi_i)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
  #(
    parameter int reset_cycles_p = 8
  )
  (
    output logic clk_o,
    output logic rst_n_o
  );

  // 10 ns period, rising edges at 5, 15, 25 ns and so on
  initial
  begin
    clk_o = 1'b0;
    forever
      #5 clk_o = ~clk_o;
  end

  // reset is released just after the last reset edge, like any other input
  initial
  begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/wh_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wh_tb;

  localparam int num_pkts_lp = 200;
  localparam int max_pkt_flits_lp = 8;
  localparam int stall_factor_lp = 8;
  // worst case flits per packet, stretched by random stalls, plus reset and drain
  localparam int timeout_cycles_lp = num_pkts_lp * max_pkt_flits_lp * stall_factor_lp + 500;

  logic                             clk;
  logic                             rst_n;

  wh_pkg::wh_hdr_u                  in_hdr;
  logic                             in_hdr_v;
  logic                             in_hdr_ready;
  logic [wh_pkg::data_width_lp-1:0] in_data;
  logic                             in_data_v;
  logic                             in_data_ready;
  wh_pkg::wh_hdr_u                  hdr;
  logic                             hdr_v;
  logic                             hdr_yumi;
  logic [wh_pkg::data_width_lp-1:0] data;
  logic                             data_v;
  logic                             data_yumi;

  integer                           seed;
  int                               cycle_cnt;

  // stimulus, all drawn before reset is released
  wh_pkg::wh_hdr_u                  pkt_hdr [num_pkts_lp];
  int                               pkt_words [num_pkts_lp];
  logic [wh_pkg::data_width_lp-1:0] pkt_data [num_pkts_lp][wh_pkg::max_words_lp];

  // reference model, expected outputs in the order they must appear
  wh_pkg::wh_hdr_u                  hdr_q [$];
  logic [wh_pkg::data_width_lp-1:0] data_q [$];
  int                               data_pkt_q [$];

  // progress on the producer side
  int                               send_idx;
  int                               cur_pkt;
  int                               word_idx;
  logic                             sending_data;
  logic                             in_hdr_fire;
  logic                             in_data_fire;
  int                               hdrs_seen;
  int                               words_seen;

  tb_clock_gen clock_gen
    (
      .clk_o   (clk),
      .rst_n_o (rst_n)
    );

  wh_loopback_top dut0
    (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .in_hdr_i        (in_hdr),
      .in_hdr_v_i      (in_hdr_v),
      .in_hdr_ready_o  (in_hdr_ready),
      .in_data_i       (in_data),
      .in_data_v_i     (in_data_v),
      .in_data_ready_o (in_data_ready),
      .hdr_o           (hdr),
      .hdr_v_o         (hdr_v),
      .hdr_yumi_i      (hdr_yumi),
      .data_o          (data),
      .data_v_o        (data_v),
      .data_yumi_i     (data_yumi)
    );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // len counts the second header flit plus two flits for each data word
  task automatic build_packets();
    logic [31:0] r;
    for (int p = 0; p < num_pkts_lp; p++)
    begin
      r = $random(seed);
      pkt_words[p] = int'(r[1:0]);
      pkt_hdr[p].fields.cord = r[2 +: wh_pkg::cord_width_lp];
      pkt_hdr[p].fields.len = wh_pkg::len_width_lp'(1 + 2 * pkt_words[p]);
      r = $random(seed);
      pkt_hdr[p].fields.pr_hdr = r[wh_pkg::pr_hdr_width_lp-1:0];
      hdr_q.push_back(pkt_hdr[p]);
      for (int w = 0; w < wh_pkg::max_words_lp; w++)
      begin
        pkt_data[p][w] = $random(seed);
        if (w < pkt_words[p])
        begin
          data_q.push_back(pkt_data[p][w]);
          data_pkt_q.push_back(p);
        end
      end
    end
  endtask

  // called 1 ns after each rising edge
  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    // whatever was taken at the last edge is withdrawn first
    if (in_hdr_fire)
      in_hdr_v = 1'b0;
    if (in_data_fire)
      in_data_v = 1'b0;
    // a new header waits until every word of the previous one was offered
    if (!in_hdr_v && !sending_data && (send_idx < num_pkts_lp) && (r[1:0] != 2'd0))
    begin
      in_hdr = pkt_hdr[send_idx];
      in_hdr_v = 1'b1;
    end
    if (!in_data_v && sending_data && (r[3:2] != 2'd0))
    begin
      in_data = pkt_data[cur_pkt][word_idx];
      in_data_v = 1'b1;
    end
    // the client acks about three times out of four while a word is valid
    hdr_yumi = hdr_v & (r[5:4] != 2'd0);
    data_yumi = data_v & (r[7:6] != 2'd0);
  endtask

  // called at the falling edge, where all handshakes are settled
  task automatic observe_cycle();
    wh_pkg::wh_hdr_u                  exp_hdr;
    logic [wh_pkg::data_width_lp-1:0] exp_data;
    int                               exp_pkt;
    in_hdr_fire = in_hdr_v & in_hdr_ready;
    in_data_fire = in_data_v & in_data_ready;
    if (in_hdr_fire)
    begin
      cur_pkt = send_idx;
      word_idx = 0;
      sending_data = (pkt_words[send_idx] != 0);
      send_idx++;
    end
    if (in_data_fire)
    begin
      word_idx++;
      if (word_idx == pkt_words[cur_pkt])
        sending_data = 1'b0;
    end
    if (hdr_v && hdr_yumi)
    begin
      if (hdr_q.size() == 0)
        abort_run("a header came out after every expected header was consumed");
      else
      begin
        exp_hdr = hdr_q.pop_front();
        check_value($sformatf("packet %0d cord", hdrs_seen),
                    32'(exp_hdr.fields.cord), 32'(hdr.fields.cord));
        check_value($sformatf("packet %0d len", hdrs_seen),
                    32'(exp_hdr.fields.len), 32'(hdr.fields.len));
        check_value($sformatf("packet %0d protocol header", hdrs_seen),
                    32'(exp_hdr.fields.pr_hdr), 32'(hdr.fields.pr_hdr));
        hdrs_seen++;
      end
    end
    if (data_v && data_yumi)
    begin
      if (data_q.size() == 0)
        abort_run("a data word came out after every expected word was consumed");
      else
      begin
        exp_data = data_q.pop_front();
        exp_pkt = data_pkt_q.pop_front();
        check_value($sformatf("packet %0d data word %0d", exp_pkt, words_seen),
                    exp_data, data);
        words_seen++;
      end
    end
  endtask

  initial
  begin
    seed = 32'h8b419281;
    in_hdr = '0;
    in_hdr_v = 1'b0;
    in_data = '0;
    in_data_v = 1'b0;
    hdr_yumi = 1'b0;
    data_yumi = 1'b0;
    send_idx = 0;
    cur_pkt = 0;
    word_idx = 0;
    sending_data = 1'b0;
    in_hdr_fire = 1'b0;
    in_data_fire = 1'b0;
    hdrs_seen = 0;
    words_seen = 0;
    build_packets();

    @(posedge rst_n);
    @(negedge clk);
    check_value("reset hdr_v_o", 32'(1'b0), 32'(hdr_v));
    check_value("reset data_v_o", 32'(1'b0), 32'(data_v));
    check_value("reset in_hdr_ready_o", 32'(1'b1), 32'(in_hdr_ready));
    check_value("reset in_data_ready_o", 32'(1'b0), 32'(in_data_ready));

    while ((hdr_q.size() != 0) || (data_q.size() != 0))
    begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      observe_cycle();
    end

    // the last acks land at the next edge, then a stray word gets time to show
    @(posedge clk);
    #1;
    in_hdr_v = 1'b0;
    in_data_v = 1'b0;
    hdr_yumi = 1'b0;
    data_yumi = 1'b0;
    repeat (10) @(negedge clk);
    if (!hdr_v && !data_v && in_hdr_ready && !in_data_ready)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("the DUT still shows valid output or is busy after the last packet");
      $display("STATUS: FAIL");
      $fatal(1, "DUT not idle at the end");
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles_lp)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d headers and %0d data words never seen",
             cycle_cnt, hdr_q.size(), data_q.size());
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- tb.f
source/wh_pkg.sv
source/wh_stream_in.sv
source/wh_flit_fifo.sv
source/wh_stream_control.sv
source/wh_flit_sipo.sv
source/wh_stream_out.sv
source/wh_loopback_top.sv
testbench/tb_clock_gen.sv
testbench/wh_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the loopback testbench and runs it, the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module wh_tb -f tb.f -Mdir obj_dir -o wh_sim \
  && ./obj_dir/wh_sim \
  || exit 1
